// File: sources.f
rtl/hazard_pkg.sv
rtl/instr_decode.sv
rtl/pipe_track.sv
rtl/forward_select.sv
rtl/hazard_unit.sv
dv/hazard_unit_assert.sv
dv/hazard_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the hazard unit testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sources.f --top-module hazard_unit_tb -Mdir "$BUILD_DIR" -o sim_hazard_unit
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_hazard_unit" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    exit 0
fi
exit 1

// File: dv/hazard_unit_tb.sv
module hazard_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hazard_pkg::*;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 2;
    localparam int N_CYCLES     = 3000;
    localparam int TIMEOUT_NS   = 2 * (N_CYCLES + RESET_CYCLES) * CLK_PERIOD;

    // weighted toward r-type and loads with two unknown opcodes at the end
    localparam logic [OP_W-1:0] OP_LIST [24] = '{
        OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_LW, OP_LW, OP_LBU, OP_LHU, OP_SW,
        OP_SB, OP_SH, OP_BEQ, OP_BNE, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_J, OP_JAL, 6'b111111, 6'b010001
    };
    localparam logic [FUNCT_W-1:0] FN_LIST [8] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_JR, FN_JR, 6'b100000, 6'b101010, 6'b100100
    };

    logic        clk = 1'b0;
    logic        arst_n;
    instr_t      instr;
    logic        instr_valid;
    logic        stall;
    fwd_bundle_t fwd;

    int stall_errs;
    int fwd_errs;
    int cover_errs;
    int stall_seen;
    int mem_fwd_seen;
    int wb_fwd_seen;

    // reference copy of execute, memory and writeback
    operand_use_t m_ex;
    stage_rec_t   m_mem;
    stage_rec_t   m_wb;

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    hazard_unit u_hazard_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr       (instr),
        .instr_valid (instr_valid),
        .stall       (stall),
        .fwd         (fwd)
    );

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////
    function automatic operand_use_t decode_word(input instr_t w);
        operand_use_t    u;
        logic [OP_W-1:0] op;
        logic            is_load;
        logic            is_store;
        logic            is_branch;
        logic            is_imm;
        logic            is_r;
        logic            is_shift;
        logic            is_jr;
        op        = w.r_fmt.op;
        is_load   = op inside {OP_LW, OP_LBU, OP_LHU};
        is_store  = op inside {OP_SW, OP_SB, OP_SH};
        is_branch = op inside {OP_BEQ, OP_BNE};
        is_imm    = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};
        is_r      = (op == OP_RTYPE);
        is_shift  = is_r && (w.r_fmt.funct inside {FN_SLL, FN_SRL, FN_SRA});
        is_jr     = is_r && (w.r_fmt.funct == FN_JR);

        u             = '0;
        u.rs          = w.r_fmt.rs;
        u.rt          = w.r_fmt.rt;
        u.use_a       = is_load || is_store || is_branch || is_imm || (is_r && !is_shift && !is_jr);
        u.use_b       = is_branch || (is_r && !is_jr);
        u.use_store   = is_store;
        u.use_jr      = is_jr;
        u.mem_read    = is_load;
        if (is_r && !is_jr) begin
            u.reg_write = 1'b1;
            u.dest      = w.r_fmt.rd;
        end else if (is_load || is_imm || op == OP_LUI) begin
            u.reg_write = 1'b1;
            u.dest      = w.r_fmt.rt;
        end else if (op == OP_JAL) begin
            u.reg_write = 1'b1;
            u.dest      = REG_RA;
        end
        return u;
    endfunction

    function automatic logic predict_stall(input logic valid, input operand_use_t id);
        logic rs_match;
        logic rt_match;
        rs_match = (id.use_a || id.use_jr) && (id.rs == m_ex.dest);
        rt_match = (id.use_b || id.use_store) && (id.rt == m_ex.dest);
        return valid && m_ex.mem_read && (m_ex.dest != REG_ZERO) && (rs_match || rt_match);
    endfunction

    function automatic fwd_sel_t pick_source(input logic used, input reg_idx_t r);
        if (!used || r == REG_ZERO) return FWD_NONE;
        if (m_mem.reg_write && m_mem.dest == r) return FWD_MEM;   // younger stage first
        if (m_wb.reg_write && m_wb.dest == r) return FWD_WB;
        return FWD_NONE;
    endfunction

    function automatic int count_source(input fwd_bundle_t b, input fwd_sel_t s);
        return int'(b.sel_a == s) + int'(b.sel_b == s) + int'(b.sel_store == s)
            + int'(b.sel_jr == s);
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus and checks
    ////////////////////////////////////////////////////////////
    function automatic instr_t rand_instr();
        instr_t w;
        w.r_fmt.op    = OP_LIST[5'($urandom_range(0, 23))];
        w.r_fmt.rs    = reg_idx_t'($urandom_range(0, 3));
        w.r_fmt.rt    = reg_idx_t'($urandom_range(0, 3));
        w.r_fmt.rd    = reg_idx_t'($urandom_range(0, 3));
        w.r_fmt.shamt = 5'($urandom);
        w.r_fmt.funct = FN_LIST[3'($urandom_range(0, 7))];
        if (w.r_fmt.op == OP_RTYPE && w.r_fmt.funct == FN_JR && $urandom_range(0, 1) == 1) begin
            w.r_fmt.rs = REG_RA;   // return after jal
        end
        return w;
    endfunction

    task automatic compare_stall(input logic got, input logic exp);
        if (got !== exp) begin
            stall_errs++;
            $display("** Error @%0t: stall is %0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic compare_fwd(input fwd_bundle_t got, input fwd_bundle_t exp);
        if (got !== exp) begin
            fwd_errs++;
            $display("** Error @%0t: fwd is %h, expected %h (a b store jr)", $time, got, exp);
        end
    endtask

    initial begin
        operand_use_t id_model;
        logic         exp_stall;
        fwd_bundle_t  exp_fwd;
        logic         held;
        void'($urandom(32'hb6b9));
        stall_errs   = 0;
        fwd_errs     = 0;
        cover_errs   = 0;
        stall_seen   = 0;
        mem_fwd_seen = 0;
        wb_fwd_seen  = 0;
        arst_n       = 1'b0;
        instr        = '0;
        instr_valid  = 1'b0;
        m_ex         = '0;
        m_mem        = '0;
        m_wb         = '0;
        held         = 1'b0;

        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;

        for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
            if (!held) begin
                instr_valid = ($urandom_range(0, 9) != 0);
                instr       = rand_instr();
            end
            #1;
            id_model          = decode_word(instr);
            exp_stall         = predict_stall(instr_valid, id_model);
            exp_fwd.sel_a     = pick_source(m_ex.use_a, m_ex.rs);
            exp_fwd.sel_b     = pick_source(m_ex.use_b, m_ex.rt);
            exp_fwd.sel_store = pick_source(m_ex.use_store, m_ex.rt);
            exp_fwd.sel_jr    = pick_source(m_ex.use_jr, m_ex.rs);
            compare_stall(stall, exp_stall);
            compare_fwd(fwd, exp_fwd);
            stall_seen   += int'(exp_stall);
            mem_fwd_seen += count_source(exp_fwd, FWD_MEM);
            wb_fwd_seen  += count_source(exp_fwd, FWD_WB);
            held = exp_stall;   // hold the word while stalled

            @(posedge clk);
            m_wb            = m_mem;
            m_mem.reg_write = m_ex.reg_write;
            m_mem.dest      = m_ex.dest;
            if (instr_valid && !exp_stall) begin
                m_ex = id_model;
            end else begin
                m_ex = '0;
            end
            @(negedge clk);
        end

        if (stall_seen == 0 || mem_fwd_seen == 0 || wb_fwd_seen == 0) begin
            cover_errs++;
            $display("stimulus never produced a stall or a forward from one of the stages");
        end
        $display("errors: stall %0d, fwd %0d, coverage %0d, assertions %0d",
            stall_errs, fwd_errs, cover_errs, u_hazard_unit.u_assert.fail_count);
        if (stall_errs + fwd_errs + cover_errs == 0 && u_hazard_unit.u_assert.fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: dv/hazard_unit_assert.sv
module hazard_unit_assert (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     stall,
    input hazard_pkg::operand_use_t ex_use,
    input hazard_pkg::fwd_bundle_t  fwd
);
    timeunit 1ns;
    timeprecision 100ps;

    import hazard_pkg::*;

    int unsigned fail_count = 0;

    ////////////////////////////////////////////////////////////
    // stall and select consistency
    ////////////////////////////////////////////////////////////
    a_stall_load: assert property (@(posedge clk) disable iff (!arst_n)
        stall |-> ex_use.mem_read)
    else begin
        $error("stall raised without a load in execute");
        fail_count++;
    end

    a_unused_none: assert property (@(posedge clk) disable iff (!arst_n)
        (!ex_use.use_a -> fwd.sel_a == FWD_NONE) && (!ex_use.use_b -> fwd.sel_b == FWD_NONE)
        && (!ex_use.use_store -> fwd.sel_store == FWD_NONE)
        && (!ex_use.use_jr -> fwd.sel_jr == FWD_NONE))
    else begin
        $error("forward select active for an unused operand");
        fail_count++;
    end

    // first edge out of reset
    a_reset_idle: assert property (@(posedge clk) $rose(arst_n) |-> (!stall && fwd == '0))
    else begin
        $error("stall or select active right after reset");
        fail_count++;
    end

endmodule

bind hazard_unit hazard_unit_assert u_assert (
    .clk    (clk),
    .arst_n (arst_n),
    .stall  (stall),
    .ex_use (ex_use),
    .fwd    (fwd)
);

// File: rtl/hazard_unit.sv
module hazard_unit (
    input  logic                    clk,
    input  logic                    arst_n,
    input  hazard_pkg::instr_t      instr,
    input  logic                    instr_valid,
    output logic                    stall,
    output hazard_pkg::fwd_bundle_t fwd
);
    import hazard_pkg::*;

    operand_use_t id_use;
    operand_use_t ex_use;
    stage_rec_t   mem_rec;
    stage_rec_t   wb_rec;

    instr_decode u_decode (
        .instr  (instr),
        .id_use (id_use)
    );

    pipe_track u_track (
        .clk         (clk),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .id_use      (id_use),
        .stall       (stall),
        .ex_use      (ex_use),
        .mem_rec     (mem_rec),
        .wb_rec      (wb_rec)
    );

    forward_select u_fwd (
        .ex_use  (ex_use),
        .mem_rec (mem_rec),
        .wb_rec  (wb_rec),
        .fwd     (fwd)
    );

endmodule

// File: rtl/forward_select.sv
module forward_select (
    input  hazard_pkg::operand_use_t ex_use,
    input  hazard_pkg::stage_rec_t   mem_rec,
    input  hazard_pkg::stage_rec_t   wb_rec,
    output hazard_pkg::fwd_bundle_t  fwd
);
    import hazard_pkg::*;

    // stage produces a usable value for src
    function automatic logic writes_reg(input stage_rec_t rec, input reg_idx_t src);
        return rec.reg_write && (rec.dest != REG_ZERO) && (rec.dest == src);
    endfunction

    // memory is younger, so it wins over writeback
    function automatic fwd_sel_t pick(
        input logic       used,
        input reg_idx_t   src,
        input stage_rec_t mem_r,
        input stage_rec_t wb_r
    );
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (used && writes_reg(mem_r, src)) begin
            sel = FWD_MEM;
        end else if (used && writes_reg(wb_r, src)) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    ////////////////////////////////////////////////////////////
    // one select per operand use
    ////////////////////////////////////////////////////////////
    always_comb begin
        fwd.sel_a     = pick(ex_use.use_a, ex_use.rs, mem_rec, wb_rec);
        fwd.sel_b     = pick(ex_use.use_b, ex_use.rt, mem_rec, wb_rec);
        fwd.sel_store = pick(ex_use.use_store, ex_use.rt, mem_rec, wb_rec);
        fwd.sel_jr    = pick(ex_use.use_jr, ex_use.rs, mem_rec, wb_rec);
    end

endmodule

// File: rtl/pipe_track.sv
module pipe_track (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     instr_valid,
    input  hazard_pkg::operand_use_t id_use,
    output logic                     stall,
    output hazard_pkg::operand_use_t ex_use,
    output hazard_pkg::stage_rec_t   mem_rec,
    output hazard_pkg::stage_rec_t   wb_rec
);
    import hazard_pkg::*;

    logic       load_in_ex;
    logic       rs_hit;
    logic       rt_hit;
    logic       accept;
    stage_rec_t ex_rec;

    ////////////////////////////////////////////////////////////
    // load-use detection
    ////////////////////////////////////////////////////////////
    always_comb begin
        load_in_ex = ex_use.mem_read && (ex_use.dest != REG_ZERO);
        rs_hit     = (id_use.use_a || id_use.use_jr) && (id_use.rs == ex_use.dest);
        rt_hit     = (id_use.use_b || id_use.use_store) && (id_use.rt == ex_use.dest);
        stall      = instr_valid && load_in_ex && (rs_hit || rt_hit);
    end

    assign accept = instr_valid && !stall;

    // write effect handed on to memory
    assign ex_rec.reg_write = ex_use.reg_write;
    assign ex_rec.dest      = ex_use.dest;

    ////////////////////////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_use  <= USE_BUBBLE;
            mem_rec <= REC_NONE;
            wb_rec  <= REC_NONE;
        end else begin
            if (accept) begin
                ex_use <= id_use;
            end else begin
                ex_use <= USE_BUBBLE;   // stalled or idle
            end
            mem_rec <= ex_rec;
            wb_rec  <= mem_rec;
        end
    end

endmodule

// File: rtl/instr_decode.sv
module instr_decode (
    input  hazard_pkg::instr_t       instr,
    output hazard_pkg::operand_use_t id_use
);
    import hazard_pkg::*;

    always_comb begin
        id_use    = USE_BUBBLE;
        id_use.rs = instr.i_fmt.rs;
        id_use.rt = instr.i_fmt.rt;

        case (instr.i_fmt.op)
            OP_LW, OP_LBU, OP_LHU: begin
                id_use.use_a     = 1'b1;
                id_use.mem_read  = 1'b1;
                id_use.reg_write = 1'b1;
                id_use.dest      = instr.i_fmt.rt;
            end

            OP_SW, OP_SB, OP_SH: begin
                id_use.use_a     = 1'b1;   // base address
                id_use.use_store = 1'b1;
            end

            OP_BEQ, OP_BNE: begin
                id_use.use_a = 1'b1;
                id_use.use_b = 1'b1;
            end

            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI: begin
                id_use.use_a     = 1'b1;
                id_use.reg_write = 1'b1;
                id_use.dest      = instr.i_fmt.rt;
            end

            OP_LUI: begin
                // immediate only yet still writes rt
                id_use.reg_write = 1'b1;
                id_use.dest      = instr.i_fmt.rt;
            end

            OP_JAL: begin
                id_use.reg_write = 1'b1;
                id_use.dest      = REG_RA;
            end

            OP_J: begin
                id_use.reg_write = 1'b0;   // no register traffic
            end

            ////////////////////////////////////////////////////////////
            // r-type split on funct
            ////////////////////////////////////////////////////////////
            OP_RTYPE: begin
                case (instr.r_fmt.funct)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        id_use.use_b     = 1'b1;   // shamt replaces rs
                        id_use.reg_write = 1'b1;
                        id_use.dest      = instr.r_fmt.rd;
                    end
                    FN_JR: begin
                        id_use.use_jr = 1'b1;
                    end
                    default: begin
                        id_use.use_a     = 1'b1;
                        id_use.use_b     = 1'b1;
                        id_use.reg_write = 1'b1;
                        id_use.dest      = instr.r_fmt.rd;
                    end
                endcase
            end

            default: begin
                id_use.reg_write = 1'b0;   // unknown opcode is inert
            end
        endcase
    end

endmodule

// File: rtl/hazard_pkg.sv
package hazard_pkg;

    ////////////////////////////////////////////////////////////
    // field widths
    ////////////////////////////////////////////////////////////
    localparam int REG_W   = 5;
    localparam int OP_W    = 6;
    localparam int FUNCT_W = 6;
    localparam int SHAMT_W = 5;
    localparam int IMM_W   = 16;

    typedef logic [REG_W-1:0] reg_idx_t;

    localparam reg_idx_t REG_ZERO = 5'd0;
    localparam reg_idx_t REG_RA   = 5'd31;   // jal link register

    ////////////////////////////////////////////////////////////
    // opcodes and funct codes
    ////////////////////////////////////////////////////////////
    localparam logic [OP_W-1:0] OP_RTYPE = 6'b000000;
    localparam logic [OP_W-1:0] OP_LW    = 6'b100011;
    localparam logic [OP_W-1:0] OP_LBU   = 6'b100100;
    localparam logic [OP_W-1:0] OP_LHU   = 6'b100101;
    localparam logic [OP_W-1:0] OP_SW    = 6'b101011;
    localparam logic [OP_W-1:0] OP_SB    = 6'b101000;
    localparam logic [OP_W-1:0] OP_SH    = 6'b101001;
    localparam logic [OP_W-1:0] OP_BEQ   = 6'b000100;
    localparam logic [OP_W-1:0] OP_BNE   = 6'b000101;
    localparam logic [OP_W-1:0] OP_ADDI  = 6'b001000;
    localparam logic [OP_W-1:0] OP_ADDIU = 6'b001001;
    localparam logic [OP_W-1:0] OP_SLTI  = 6'b001010;
    localparam logic [OP_W-1:0] OP_SLTIU = 6'b001011;
    localparam logic [OP_W-1:0] OP_ANDI  = 6'b001100;
    localparam logic [OP_W-1:0] OP_ORI   = 6'b001101;
    localparam logic [OP_W-1:0] OP_XORI  = 6'b001110;
    localparam logic [OP_W-1:0] OP_LUI   = 6'b001111;
    localparam logic [OP_W-1:0] OP_J     = 6'b000010;
    localparam logic [OP_W-1:0] OP_JAL   = 6'b000011;

    localparam logic [FUNCT_W-1:0] FN_SLL = 6'b000000;
    localparam logic [FUNCT_W-1:0] FN_SRL = 6'b000010;
    localparam logic [FUNCT_W-1:0] FN_SRA = 6'b000011;
    localparam logic [FUNCT_W-1:0] FN_JR  = 6'b001000;

    ////////////////////////////////////////////////////////////
    // two views of the same 32-bit instruction word
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [OP_W-1:0]    op;
        reg_idx_t           rs;
        reg_idx_t           rt;
        reg_idx_t           rd;
        logic [SHAMT_W-1:0] shamt;
        logic [FUNCT_W-1:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [OP_W-1:0]  op;
        reg_idx_t         rs;
        reg_idx_t         rt;
        logic [IMM_W-1:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

    // register uses and write effect of one instruction
    typedef struct packed {
        reg_idx_t rs;
        reg_idx_t rt;
        logic     use_a;       // rs -> alu a
        logic     use_b;       // rt -> alu b
        logic     use_store;   // rt is store data
        logic     use_jr;      // rs is jump target
        logic     mem_read;
        logic     reg_write;
        reg_idx_t dest;
    } operand_use_t;

    typedef struct packed {
        logic     reg_write;
        reg_idx_t dest;
    } stage_rec_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,
        FWD_MEM  = 2'b01,
        FWD_WB   = 2'b10
    } fwd_sel_t;

    typedef struct packed {
        fwd_sel_t sel_a;
        fwd_sel_t sel_b;
        fwd_sel_t sel_store;
        fwd_sel_t sel_jr;
    } fwd_bundle_t;

    localparam operand_use_t USE_BUBBLE = '0;
    localparam stage_rec_t   REC_NONE   = '0;

endpackage
